//--- source/bp_director_pkg.sv
package bp_director_pkg;

  localparam int vaddr_width_c    = 39;
  localparam int metadata_width_c = 16;

  // Front-end command opcodes
  typedef enum logic [2:0] {
    e_op_state_reset  = 3'd0,
    e_op_pc_redirect  = 3'd1,
    e_op_icache_fence = 3'd2,
    e_op_wait         = 3'd3,
    e_op_attaboy      = 3'd4
  } fe_opcode_e;

  typedef enum logic [1:0] {
    e_subop_trap              = 2'd0,
    e_subop_eret              = 2'd1,
    e_subop_branch_mispredict = 2'd2
  } redirect_subop_e;

  typedef enum logic [1:0] {
    e_not_a_branch      = 2'd0,
    e_pred_taken_wrong  = 2'd1,
    e_pred_ntaken_wrong = 2'd2
  } mispredict_reason_e;

  // One commit slot
  typedef struct packed {
    logic                     npc_w_v;
    logic [vaddr_width_c-1:0] npc;
    logic                     unfreeze;
    logic                     exception;
    logic                     interrupt;
    logic                     eret;
    logic                     fencei;
    logic                     wfi;
  } commit_pkt_s;

  // Resolved branch from execute
  typedef struct packed {
    logic                     v;
    logic                     branch;
    logic                     btaken;
    logic [vaddr_width_c-1:0] npc;
  } br_pkt_s;

  typedef struct packed {
    logic                        v;
    logic [vaddr_width_c-1:0]    pc;
    logic [metadata_width_c-1:0] metadata;
  } isd_status_s;

  // Unused fields stay zero
  typedef struct packed {
    fe_opcode_e                  opcode;
    logic [vaddr_width_c-1:0]    vaddr;
    redirect_subop_e             subopcode;
    mispredict_reason_e          reason;
    logic                        taken;
    logic [metadata_width_c-1:0] metadata;
  } fe_cmd_s;

  typedef struct packed {
    logic    v;
    fe_cmd_s cmd;
  } cmd_req_s;

endpackage

//--- source/npc_tracker.sv
`timescale 1ns/1ps

module npc_tracker
  (input                                               clk_i
   , input                                             reset_i
   , input  bp_director_pkg::br_pkt_s                  br_pkt_i
   , input  bp_director_pkg::isd_status_s              isd_status_i
   , input  bp_director_pkg::commit_pkt_s              commit0_i
   , input  bp_director_pkg::commit_pkt_s              commit1_i
   , output logic [bp_director_pkg::vaddr_width_c-1:0] expected_npc_o
   , output logic [bp_director_pkg::vaddr_width_c-1:0] npc_r_o
   , output logic                                      poison_isd_o
   , output bp_director_pkg::cmd_req_s                 issue_req_o
   );

  import bp_director_pkg::*;

  logic [vaddr_width_c-1:0] npc_n;
  logic [vaddr_width_c-1:0] npc_r;
  logic                     npc_w_v;
  logic                     npc_mismatch;
  logic                     br_seen;
  logic                     branch_pending_r;
  logic                     btaken_pending_r;
  logic                     last_branch;
  logic                     last_btaken;

  // Commits override the branch unit
  assign npc_w_v = commit0_i.npc_w_v | commit1_i.npc_w_v | br_pkt_i.v;
  assign npc_n   = commit0_i.npc_w_v ? commit0_i.npc
                 : commit1_i.npc_w_v ? commit1_i.npc
                 : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      npc_r <= '0;
    else if (npc_w_v)
      npc_r <= npc_n;
  end

  assign expected_npc_o = npc_w_v ? npc_n : npc_r;
  assign npc_r_o        = npc_r;
  assign npc_mismatch   = isd_status_i.v & (isd_status_i.pc != expected_npc_o);
  assign poison_isd_o   = npc_mismatch;

  // Remember the last branch until the next issue
  assign br_seen = br_pkt_i.v & br_pkt_i.branch;

  always_ff @(posedge clk_i)
  begin
    if (reset_i | isd_status_i.v)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else if (br_seen)
    begin
      branch_pending_r <= 1'b1;
      btaken_pending_r <= br_pkt_i.btaken;
    end
  end

  assign last_branch = br_seen | branch_pending_r;
  assign last_btaken = br_seen ? br_pkt_i.btaken : btaken_pending_r;

  always_comb
  begin
    issue_req_o = '0;
    if (npc_mismatch)
    begin
      issue_req_o.v                = 1'b1;
      issue_req_o.cmd.opcode       = e_op_pc_redirect;
      issue_req_o.cmd.vaddr        = expected_npc_o;
      issue_req_o.cmd.subopcode    = e_subop_branch_mispredict;
      issue_req_o.cmd.reason       = last_branch
                                     ? (last_btaken ? e_pred_taken_wrong : e_pred_ntaken_wrong)
                                     : e_not_a_branch;
      issue_req_o.cmd.metadata     = isd_status_i.metadata;
    end
    // Correct prediction after a branch
    else if (isd_status_i.v & last_branch)
    begin
      issue_req_o.v            = 1'b1;
      issue_req_o.cmd.opcode   = e_op_attaboy;
      issue_req_o.cmd.vaddr    = expected_npc_o;
      issue_req_o.cmd.taken    = last_btaken;
      issue_req_o.cmd.metadata = isd_status_i.metadata;
    end
  end

endmodule

//--- source/commit_cmd_encoder.sv
`timescale 1ns/1ps

module commit_cmd_encoder
  (input  bp_director_pkg::commit_pkt_s              commit_i
   , input  [bp_director_pkg::vaddr_width_c-1:0]     npc_r_i
   , input                                           in_wait_i
   , input                                           irq_waiting_i
   , output bp_director_pkg::cmd_req_s               req_o
   );

  import bp_director_pkg::*;

  logic trap_v;

  // A pending interrupt wakes the core out of wait
  assign trap_v = commit_i.exception
                | commit_i.interrupt
                | (in_wait_i & irq_waiting_i);

  always_comb
  begin
    req_o = '0;
    if (commit_i.unfreeze)
    begin
      // Restart fetch from the registered npc
      req_o.v          = 1'b1;
      req_o.cmd.opcode = e_op_state_reset;
      req_o.cmd.vaddr  = npc_r_i;
    end
    else if (commit_i.fencei)
    begin
      req_o.v          = 1'b1;
      req_o.cmd.opcode = e_op_icache_fence;
      req_o.cmd.vaddr  = commit_i.npc;
    end
    else if (commit_i.wfi)
    begin
      req_o.v          = 1'b1;
      req_o.cmd.opcode = e_op_wait;
      req_o.cmd.vaddr  = commit_i.npc;
    end
    else if (commit_i.eret)
    begin
      req_o.v             = 1'b1;
      req_o.cmd.opcode    = e_op_pc_redirect;
      req_o.cmd.vaddr     = commit_i.npc;
      req_o.cmd.subopcode = e_subop_eret;
    end
    else if (trap_v)
    begin
      req_o.v             = 1'b1;
      req_o.cmd.opcode    = e_op_pc_redirect;
      req_o.cmd.vaddr     = commit_i.npc;
      req_o.cmd.subopcode = e_subop_trap;
    end
  end

endmodule

//--- source/cmd_arbiter.sv
`timescale 1ns/1ps

module cmd_arbiter
  (input  bp_director_pkg::cmd_req_s  slot0_req_i
   , input  bp_director_pkg::cmd_req_s  slot1_req_i
   , input  bp_director_pkg::cmd_req_s  issue_req_i
   , input                              queue_full_i
   , output logic                       enq_v_o
   , output bp_director_pkg::fe_cmd_s   enq_cmd_o
   , output logic                       nonattaboy_v_o
   );

  import bp_director_pkg::*;

  cmd_req_s grant;

  // Fixed priority with losing requests dropped
  always_comb
  begin
    if (slot0_req_i.v)
      grant = slot0_req_i;
    else if (slot1_req_i.v)
      grant = slot1_req_i;
    else
      grant = issue_req_i;
  end

  assign enq_v_o   = grant.v & ~queue_full_i;
  assign enq_cmd_o = grant.cmd;

  // Anything but an attaboy makes the FSM fence
  assign nonattaboy_v_o = enq_v_o & (grant.cmd.opcode != e_op_attaboy);

endmodule

//--- source/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue
  #(parameter int cmd_queue_els_p = 4)
  (input                              clk_i
   , input                            reset_i
   , input                            enq_v_i
   , input  bp_director_pkg::fe_cmd_s enq_cmd_i
   , input                            fe_cmd_yumi_i
   , output bp_director_pkg::fe_cmd_s fe_cmd_o
   , output logic                     fe_cmd_v_o
   , output logic                     empty_n_o
   , output logic                     full_o
   );

  import bp_director_pkg::*;

  localparam int ptr_width_lp   = (cmd_queue_els_p > 1) ? $clog2(cmd_queue_els_p) : 1;
  localparam int count_width_lp = $clog2(cmd_queue_els_p + 1);

  fe_cmd_s                   mem_r [cmd_queue_els_p];
  logic [ptr_width_lp-1:0]   rptr_r;
  logic [ptr_width_lp-1:0]   wptr_r;
  logic [count_width_lp-1:0] count_r;
  logic [count_width_lp-1:0] count_n;
  logic                      push;
  logic                      pop;

  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
    ptr_inc = (ptr == ptr_width_lp'(cmd_queue_els_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = enq_v_i & ~full_o;
  assign pop  = fe_cmd_yumi_i & fe_cmd_v_o;

  always_comb
  begin
    count_n = count_r;
    if (push & ~pop)
      count_n = count_r + 1'b1;
    else if (pop & ~push)
      count_n = count_r - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push)
        wptr_r <= ptr_inc(wptr_r);
      if (pop)
        rptr_r <= ptr_inc(rptr_r);
      count_r <= count_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wptr_r] <= enq_cmd_i;
  end

  assign fe_cmd_o   = mem_r[rptr_r];
  assign fe_cmd_v_o = (count_r != '0);
  assign full_o     = (count_r == count_width_lp'(cmd_queue_els_p));
  // Empty once this edge has passed
  assign empty_n_o  = (count_n == '0);

endmodule

//--- source/director_fsm.sv
`timescale 1ns/1ps

module director_fsm
  (input          clk_i
   , input        reset_i
   , input        freeze_i
   , input        wfi_commit_i
   , input        nonattaboy_v_i
   , input        queue_empty_n_i
   , output logic suppress_iss_o
   , output logic unfreeze_o
   , output logic in_wait_o
   );

  typedef enum logic [1:0] {
    e_freeze,
    e_wait,
    e_fence,
    e_run
  } state_e;

  state_e state_r;
  state_e state_n;

  always_comb
  begin
    unique case (state_r)
      e_freeze: state_n = freeze_i ? e_freeze : e_wait;
      e_wait:   state_n = nonattaboy_v_i ? e_fence : e_wait;
      // wfi wins over a redirect in the same cycle
      e_run:    state_n = wfi_commit_i ? e_wait : (nonattaboy_v_i ? e_fence : e_run);
      e_fence:  state_n = queue_empty_n_i ? e_run : e_fence;
      default:  state_n = e_freeze;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_freeze;
    else
      state_r <= state_n;
  end

  assign suppress_iss_o = (state_r != e_run);
  assign unfreeze_o     = (state_r == e_freeze) & ~freeze_i;
  assign in_wait_o      = (state_r == e_wait);

endmodule

//--- source/bp_director.sv
`timescale 1ns/1ps

module bp_director
  #(parameter int cmd_queue_els_p = 4)
  (input                                               clk_i
   , input                                             reset_i
   , input                                             freeze_i
   , input                                             irq_waiting_i
   , input  bp_director_pkg::br_pkt_s                  br_pkt_i
   , input  bp_director_pkg::isd_status_s              isd_status_i
   , input  bp_director_pkg::commit_pkt_s              commit0_i
   , input  bp_director_pkg::commit_pkt_s              commit1_i
   , input                                             fe_cmd_yumi_i
   , output logic [bp_director_pkg::vaddr_width_c-1:0] expected_npc_o
   , output logic                                      poison_isd_o
   , output logic                                      suppress_iss_o
   , output logic                                      unfreeze_o
   , output bp_director_pkg::fe_cmd_s                  fe_cmd_o
   , output logic                                      fe_cmd_v_o
   , output logic                                      cmd_full_o
   );

  import bp_director_pkg::*;

  logic [vaddr_width_c-1:0] npc_r;
  cmd_req_s                 slot0_req;
  cmd_req_s                 slot1_req;
  cmd_req_s                 issue_req;
  fe_cmd_s                  enq_cmd;
  logic                     enq_v;
  logic                     nonattaboy_v;
  logic                     queue_empty_n;
  logic                     in_wait;
  logic                     wfi_commit;

  assign wfi_commit = commit0_i.wfi | commit1_i.wfi;

  npc_tracker tracker
    (.clk_i(clk_i), .reset_i(reset_i), .br_pkt_i(br_pkt_i), .isd_status_i(isd_status_i)
     , .commit0_i(commit0_i), .commit1_i(commit1_i), .expected_npc_o(expected_npc_o)
     , .npc_r_o(npc_r), .poison_isd_o(poison_isd_o), .issue_req_o(issue_req));

  commit_cmd_encoder slot0_enc
    (.commit_i(commit0_i), .npc_r_i(npc_r), .in_wait_i(in_wait)
     , .irq_waiting_i(irq_waiting_i), .req_o(slot0_req));

  commit_cmd_encoder slot1_enc
    (.commit_i(commit1_i), .npc_r_i(npc_r), .in_wait_i(in_wait)
     , .irq_waiting_i(irq_waiting_i), .req_o(slot1_req));

  cmd_arbiter arb
    (.slot0_req_i(slot0_req), .slot1_req_i(slot1_req), .issue_req_i(issue_req)
     , .queue_full_i(cmd_full_o), .enq_v_o(enq_v), .enq_cmd_o(enq_cmd)
     , .nonattaboy_v_o(nonattaboy_v));

  cmd_queue #(.cmd_queue_els_p(cmd_queue_els_p)) fe_cmd_fifo
    (.clk_i(clk_i), .reset_i(reset_i), .enq_v_i(enq_v), .enq_cmd_i(enq_cmd)
     , .fe_cmd_yumi_i(fe_cmd_yumi_i), .fe_cmd_o(fe_cmd_o), .fe_cmd_v_o(fe_cmd_v_o)
     , .empty_n_o(queue_empty_n), .full_o(cmd_full_o));

  director_fsm fsm
    (.clk_i(clk_i), .reset_i(reset_i), .freeze_i(freeze_i), .wfi_commit_i(wfi_commit)
     , .nonattaboy_v_i(nonattaboy_v), .queue_empty_n_i(queue_empty_n)
     , .suppress_iss_o(suppress_iss_o), .unfreeze_o(unfreeze_o), .in_wait_o(in_wait));

endmodule

//--- bench/bp_director_props.sv
`timescale 1ns/1ps

module bp_director_props
  (input    clk_i
   , input  reset_i
   , input  queue_empty_n_i
   , input  enq_v_i
   , input  fe_cmd_v_i
   , input  suppress_iss_i
   , input  unfreeze_i
   );

  // An empty queue stays empty until a command is written
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (!fe_cmd_v_i && !enq_v_i) |=> !fe_cmd_v_i)
    else $error("fe_cmd_v_o rose with no command written to the queue");

  assert property (@(posedge clk_i) reset_i |=> suppress_iss_i)
    else $error("suppress_iss_o low right after reset");

  // Run is only entered from fence once the queue drains
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (suppress_iss_i && !queue_empty_n_i) |=> suppress_iss_i)
    else $error("suppress_iss_o fell before run was reached");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   unfreeze_i |=> !unfreeze_i)
    else $error("unfreeze_o lasted more than one cycle");

endmodule

bind bp_director bp_director_props props
  (.clk_i(clk_i), .reset_i(reset_i), .queue_empty_n_i(queue_empty_n), .enq_v_i(enq_v)
   , .fe_cmd_v_i(fe_cmd_v_o), .suppress_iss_i(suppress_iss_o), .unfreeze_i(unfreeze_o));

//--- bench/tb_bp_director.sv
`timescale 1ns/1ps

module tb_bp_director;

  import bp_director_pkg::*;

  localparam int queue_els_lp     = 4;
  localparam int timeout_cycles_lp = 2000;
  localparam logic [1:0] s_freeze = 2'd0;
  localparam logic [1:0] s_wait   = 2'd1;
  localparam logic [1:0] s_fence  = 2'd2;
  localparam logic [1:0] s_run    = 2'd3;

  logic clk_i;
  logic reset_i;
  logic freeze_i;
  logic irq_waiting_i;
  logic fe_cmd_yumi_i;
  br_pkt_s br_pkt_i;
  isd_status_s isd_status_i;
  commit_pkt_s commit0_i;
  commit_pkt_s commit1_i;
  logic [vaddr_width_c-1:0] expected_npc_o;
  logic poison_isd_o;
  logic suppress_iss_o;
  logic unfreeze_o;
  fe_cmd_s fe_cmd_o;
  logic fe_cmd_v_o;
  logic cmd_full_o;

  integer seed = 32'h49ae;
  integer errors = 0;
  integer checks = 0;
  integer cycle_count = 0;
  string test_name = "reset";
  logic hold_yumi;
  logic yumi_phase;
  fe_cmd_s exp_q[$];

  // Reference model state
  logic [vaddr_width_c-1:0] m_npc;
  logic [vaddr_width_c-1:0] m_enpc;
  logic m_bpend;
  logic m_tpend;
  logic [1:0] m_state;
  cmd_req_s m_req;
  fe_cmd_s m_exp;
  logic m_push;
  logic m_pop;
  logic m_nonatt;

  bp_director #(.cmd_queue_els_p(queue_els_lp)) DUT
    (.clk_i(clk_i), .reset_i(reset_i), .freeze_i(freeze_i), .irq_waiting_i(irq_waiting_i)
     , .br_pkt_i(br_pkt_i), .isd_status_i(isd_status_i), .commit0_i(commit0_i)
     , .commit1_i(commit1_i), .fe_cmd_yumi_i(fe_cmd_yumi_i), .expected_npc_o(expected_npc_o)
     , .poison_isd_o(poison_isd_o), .suppress_iss_o(suppress_iss_o), .unfreeze_o(unfreeze_o)
     , .fe_cmd_o(fe_cmd_o), .fe_cmd_v_o(fe_cmd_v_o), .cmd_full_o(cmd_full_o));

  always #2 clk_i = ~clk_i;

  function automatic logic [vaddr_width_c-1:0] rand_vaddr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[vaddr_width_c-1:0];
  endfunction

  // Flag bits from 0 up are fencei, wfi, eret, exception and interrupt
  function automatic commit_pkt_s make_commit(input logic [4:0] flags,
                                              input logic [vaddr_width_c-1:0] npc);
    commit_pkt_s c;
    c = '0;
    c.npc_w_v   = 1'b1;
    c.npc       = npc;
    c.fencei    = flags[0];
    c.wfi       = flags[1];
    c.eret      = flags[2];
    c.exception = flags[3];
    c.interrupt = flags[4];
    return c;
  endfunction

  function automatic logic [vaddr_width_c-1:0] model_npc(input commit_pkt_s c0,
                                                         input commit_pkt_s c1,
                                                         input br_pkt_s br,
                                                         input logic [vaddr_width_c-1:0] npc_r);
    if (c0.npc_w_v)
      return c0.npc;
    else if (c1.npc_w_v)
      return c1.npc;
    else if (br.v)
      return br.npc;
    return npc_r;
  endfunction

  function automatic cmd_req_s slot_cmd(input commit_pkt_s c,
                                        input logic [vaddr_width_c-1:0] npc_r,
                                        input logic in_wait, input logic irq);
    cmd_req_s r;
    r = '0;
    r.v = 1'b1;
    r.cmd.vaddr = c.npc;
    if (c.unfreeze)
    begin
      r.cmd.opcode = e_op_state_reset;
      r.cmd.vaddr  = npc_r;
    end
    else if (c.fencei)
      r.cmd.opcode = e_op_icache_fence;
    else if (c.wfi)
      r.cmd.opcode = e_op_wait;
    else if (c.eret)
    begin
      r.cmd.opcode    = e_op_pc_redirect;
      r.cmd.subopcode = e_subop_eret;
    end
    else if (c.exception || c.interrupt || (in_wait && irq))
    begin
      r.cmd.opcode    = e_op_pc_redirect;
      r.cmd.subopcode = e_subop_trap;
    end
    else
      r = '0;
    return r;
  endfunction

  function automatic cmd_req_s predict_cmd(input commit_pkt_s c0, input commit_pkt_s c1,
                                           input br_pkt_s br, input isd_status_s isd,
                                           input logic irq, input logic in_wait,
                                           input logic [vaddr_width_c-1:0] npc_r,
                                           input logic bpend, input logic tpend);
    cmd_req_s r0;
    cmd_req_s r1;
    cmd_req_s r;
    logic [vaddr_width_c-1:0] enpc;
    logic lb;
    logic lt;
    r0   = slot_cmd(c0, npc_r, in_wait, irq);
    r1   = slot_cmd(c1, npc_r, in_wait, irq);
    enpc = model_npc(c0, c1, br, npc_r);
    lb   = (br.v && br.branch) || bpend;
    lt   = (br.v && br.branch) ? br.btaken : tpend;
    r    = '0;
    if (r0.v)
      r = r0;
    else if (r1.v)
      r = r1;
    else if (isd.v && (isd.pc != enpc))
    begin
      r.v             = 1'b1;
      r.cmd.opcode    = e_op_pc_redirect;
      r.cmd.vaddr     = enpc;
      r.cmd.subopcode = e_subop_branch_mispredict;
      r.cmd.reason    = !lb ? e_not_a_branch : (lt ? e_pred_taken_wrong : e_pred_ntaken_wrong);
      r.cmd.metadata  = isd.metadata;
    end
    else if (isd.v && lb)
    begin
      r.v            = 1'b1;
      r.cmd.opcode   = e_op_attaboy;
      r.cmd.vaddr    = enpc;
      r.cmd.taken    = lt;
      r.cmd.metadata = isd.metadata;
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks = checks + 1;
    if (exp !== act)
    begin
      errors = errors + 1;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Sampled 1 ns before the rising edge
  always @(negedge clk_i)
  begin
    #1;
    if (reset_i)
    begin
      m_npc   = '0;
      m_bpend = 1'b0;
      m_tpend = 1'b0;
      m_state = s_freeze;
      exp_q.delete();
    end
    else
    begin
      m_enpc = model_npc(commit0_i, commit1_i, br_pkt_i, m_npc);
      check_value("expected_npc", 64'(m_enpc), 64'(expected_npc_o));
      check_value("poison", 64'(isd_status_i.v && (isd_status_i.pc != m_enpc)),
                  64'(poison_isd_o));
      check_value("fe_cmd_v", 64'(exp_q.size() != 0), 64'(fe_cmd_v_o));
      check_value("cmd_full", 64'(exp_q.size() == queue_els_lp), 64'(cmd_full_o));
      check_value("suppress", 64'(m_state != s_run), 64'(suppress_iss_o));
      check_value("unfreeze", 64'((m_state == s_freeze) && !freeze_i), 64'(unfreeze_o));
      m_req  = predict_cmd(commit0_i, commit1_i, br_pkt_i, isd_status_i, irq_waiting_i,
                           m_state == s_wait, m_npc, m_bpend, m_tpend);
      m_push = m_req.v && (exp_q.size() < queue_els_lp);
      m_pop  = fe_cmd_v_o && fe_cmd_yumi_i;
      if (m_pop)
      begin
        if (exp_q.size() == 0)
        begin
          errors = errors + 1;
          $display("%s: front end accepted a command that was never expected", test_name);
        end
        else
        begin
          m_exp = exp_q.pop_front();
          check_value("fe_cmd", 64'(m_exp), 64'(fe_cmd_o));
        end
      end
      if (m_push)
        exp_q.push_back(m_req.cmd);
      m_nonatt = m_push && (m_req.cmd.opcode != e_op_attaboy);
      case (m_state)
        s_freeze: m_state = freeze_i ? s_freeze : s_wait;
        s_wait:   m_state = m_nonatt ? s_fence : s_wait;
        s_run:    m_state = (commit0_i.wfi || commit1_i.wfi) ? s_wait
                          : (m_nonatt ? s_fence : s_run);
        s_fence:  m_state = (exp_q.size() == 0) ? s_run : s_fence;
      endcase
      m_npc = m_enpc;
      if (isd_status_i.v)
      begin
        m_bpend = 1'b0;
        m_tpend = 1'b0;
      end
      else if (br_pkt_i.v && br_pkt_i.branch)
      begin
        m_bpend = 1'b1;
        m_tpend = br_pkt_i.btaken;
      end
    end
  end

  // Front end accepts every other cycle
  always @(negedge clk_i)
  begin
    yumi_phase = ~yumi_phase;
    if (reset_i || hold_yumi)
      fe_cmd_yumi_i = 1'b0;
    else
      fe_cmd_yumi_i = fe_cmd_v_o & yumi_phase;
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp)
    begin
      $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic clear_inputs();
    br_pkt_i      = '0;
    isd_status_i  = '0;
    commit0_i     = '0;
    commit1_i     = '0;
    irq_waiting_i = 1'b0;
  endtask

  task automatic drain();
    hold_yumi = 1'b0;
    while (fe_cmd_v_o)
      @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic wait_run();
    while (suppress_iss_o)
      @(negedge clk_i);
  endtask

  task automatic branch_then_issue(input logic taken, input logic is_branch,
                                   input logic hit, input logic same_cycle);
    logic [vaddr_width_c-1:0] npc;
    logic [31:0] r;
    npc = rand_vaddr();
    r   = $random(seed);
    @(negedge clk_i);
    br_pkt_i.v      = 1'b1;
    br_pkt_i.branch = is_branch;
    br_pkt_i.btaken = taken;
    br_pkt_i.npc    = npc;
    if (!same_cycle)
    begin
      @(negedge clk_i);
      clear_inputs();
    end
    isd_status_i.v        = 1'b1;
    isd_status_i.pc       = hit ? npc : npc + 39'd4;
    isd_status_i.metadata = r[15:0];
    #1;
    check_value("poison_isd", 64'(!hit), 64'(poison_isd_o));
    @(negedge clk_i);
    clear_inputs();
    drain();
  endtask

  initial
  begin
    int kind;
    int slot;
    logic [31:0] r;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    freeze_i   = 1'b1;
    hold_yumi  = 1'b0;
    yumi_phase = 1'b0;
    fe_cmd_yumi_i = 1'b0;
    clear_inputs();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "boot";
    repeat (3) @(negedge clk_i);
    check_value("suppress_iss", 64'(1'b1), 64'(suppress_iss_o));
    check_value("fe_cmd_v", 64'(1'b0), 64'(fe_cmd_v_o));
    br_pkt_i.v   = 1'b1;
    br_pkt_i.npc = 39'h00_8000_1000;
    @(negedge clk_i);
    clear_inputs();
    freeze_i = 1'b0;
    repeat (3) @(negedge clk_i);
    commit0_i.unfreeze = 1'b1;
    @(negedge clk_i);
    clear_inputs();
    drain();
    wait_run();

    test_name = "mispredict";
    for (int i = 0; i < 6; i++)
    begin
      r = $random(seed);
      branch_then_issue(r[0], i != 0, 1'b0, i[0]);
      wait_run();
    end

    test_name = "attaboy";
    for (int i = 0; i < 6; i++)
      branch_then_issue(i[1], 1'b1, 1'b1, i[0]);

    test_name = "commit_events";
    for (int i = 0; i < 20; i++)
    begin
      kind = $unsigned($random(seed)) % 5;
      slot = $unsigned($random(seed)) % 3;
      r    = $random(seed);
      @(negedge clk_i);
      // Extra flags now and then exercise the priority chain
      if (slot != 1)
        commit0_i = make_commit((5'b1 << kind) | (r[4:0] & r[9:5]), rand_vaddr());
      if (slot != 0)
        commit1_i = make_commit((5'b1 << ($unsigned($random(seed)) % 5))
                                | (r[14:10] & r[19:15]), rand_vaddr());
      @(negedge clk_i);
      clear_inputs();
      drain();
    end

    test_name = "wait_interrupt";
    @(negedge clk_i);
    commit0_i = make_commit(5'b00100, rand_vaddr());
    @(negedge clk_i);
    clear_inputs();
    drain();
    wait_run();
    commit0_i = make_commit(5'b00010, rand_vaddr());
    @(negedge clk_i);
    clear_inputs();
    drain();
    repeat (4) @(negedge clk_i);
    check_value("suppress_iss", 64'(1'b1), 64'(suppress_iss_o));
    irq_waiting_i = 1'b1;
    @(negedge clk_i);
    clear_inputs();
    drain();
    wait_run();

    test_name = "back_pressure";
    hold_yumi = 1'b1;
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < queue_els_lp + 2; i++)
    begin
      commit0_i = make_commit(5'b00001, rand_vaddr());
      @(negedge clk_i);
    end
    clear_inputs();
    repeat (2) @(negedge clk_i);
    check_value("cmd_full", 64'(1'b1), 64'(cmd_full_o));
    drain();
    wait_run();

    repeat (5) @(negedge clk_i);
    if (exp_q.size() != 0)
    begin
      errors = errors + 1;
      $display("%0d expected commands never reached the front end", exp_q.size());
    end
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- bp_director.f
source/bp_director_pkg.sv
source/npc_tracker.sv
source/commit_cmd_encoder.sv
source/cmd_arbiter.sv
source/cmd_queue.sv
source/director_fsm.sv
source/bp_director.sv
bench/bp_director_props.sv
bench/tb_bp_director.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the bp_director testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --assert --top-module tb_bp_director -f bp_director.f \
  -o sim_bp_director > build.log 2>&1 \
  && ./obj_dir/sim_bp_director > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; }

grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
